/* sources.f */
hw/connPkg.sv
hw/ringMemory.sv
hw/graphFifo.sv
hw/componentCounter.sv
hw/sideDataStore.sv
hw/streamingConnCore.sv
test/clockGen.sv
test/connChecker.sv
test/connCoreTb.sv

/* Bender.yml */
package:
  name: streaming_conn_core

dependencies: {}

sources:
  - files:
      - hw/connPkg.sv
      - hw/ringMemory.sv
      - hw/graphFifo.sv
      - hw/componentCounter.sv
      - hw/sideDataStore.sv
      - hw/streamingConnCore.sv
  - target: test
    files:
      - test/clockGen.sv
      - test/connChecker.sv
      - test/connCoreTb.sv

/* test/connCoreTb.sv */
`timescale 1ns/1ps

module connCoreTb
    import connPkg::*;
();

    localparam int EXTRA_W = 4;
    localparam int NUM_TESTS = 6;
    localparam int KNOWN_GAP = 40;
    localparam int SPARSE_BOTS = 24;
    localparam int SPARSE_GAP = 36;
    localparam int SPARSE_JITTER = 16;
    localparam int BURSTS = 3;
    localparam int BURST_LEN = 1 << FIFO_DEPTH_LOG2;
    localparam int BURST_GAP = 160;
    localparam int PATTERN_GROUPS = 3;
    localparam int PATTERN_LEN = 8;
    localparam int NEW_TOP_BOTS = 16;
    localparam int DRAIN_LIMIT = RING_DEPTH + 16;

    // Stimulus of all tests plus one drain per test and two revolutions
    localparam int STIMULUS_CYCLES = RING_DEPTH + 3 * (KNOWN_GAP + 1)
        + (SPARSE_BOTS + NEW_TOP_BOTS) * (SPARSE_GAP + SPARSE_JITTER + 1)
        + BURSTS * (BURST_LEN + BURST_GAP) + PATTERN_GROUPS * (PATTERN_LEN + BURST_GAP);
    localparam int WATCHDOG_CYCLES = STIMULUS_CYCLES + NUM_TESTS * DRAIN_LIMIT + 2 * RING_DEPTH;

    logic clk;
    logic rstN;
    graphT top;
    logic isBotValid;
    graphT bot;
    logic [EXTRA_W-1:0] extraDataIn;
    logic [FIFO_DEPTH_LOG2:0] usedw;
    logic resultValid;
    countT connectCount;
    logic [EXTRA_W-1:0] extraDataOut;
    logic fifoMustBeEmpty;
    int checkCount;
    int errorCount;
    int pendingCount;
    int checkBase;
    int errorBase;
    int seed;

    clockGen clockGen0 (.clk(clk), .rstN(rstN));

    streamingConnCore #(.EXTRA_W(EXTRA_W)) dut0 (
        .clk(clk),
        .rstN(rstN),
        .top(top),
        .isBotValid(isBotValid),
        .bot(bot),
        .extraDataIn(extraDataIn),
        .usedw(usedw),
        .resultValid(resultValid),
        .connectCount(connectCount),
        .extraDataOut(extraDataOut)
    );

    connChecker #(.EXTRA_W(EXTRA_W)) checker0 (
        .clk(clk),
        .rstN(rstN),
        .top(top),
        .isBotValid(isBotValid),
        .bot(bot),
        .extraDataIn(extraDataIn),
        .usedw(usedw),
        .fifoMustBeEmpty(fifoMustBeEmpty),
        .resultValid(resultValid),
        .connectCount(connectCount),
        .extraDataOut(extraDataOut),
        .checkCount(checkCount),
        .errorCount(errorCount),
        .pendingCount(pendingCount)
    );

    task automatic driveCycle(input logic valid, input graphT botSet);
        @(posedge clk);
        isBotValid <= valid;
        bot <= botSet;
        extraDataIn <= EXTRA_W'($random(seed));
    endtask

    // Idle slots still carry random payload
    task automatic idleCycles(input int count);
        repeat (count) begin
            driveCycle(1'b0, graphT'($random(seed)));
        end
    endtask

    // Every queued result has come out once the checker queue is empty
    task automatic finishTest(input int number, input string name);
        wait (pendingCount == 0);
        $display("test %0d %s: %0d results checked, %0d errors", number, name,
                 checkCount - checkBase, errorCount - errorBase);
        checkBase = checkCount;
        errorBase = errorCount;
    endtask

    initial begin : stimulus
        logic valid;
        int sent;
        graphT newTop;
        seed = 32'h53e7_a782;
        top = '1;
        isBotValid = 1'b0;
        bot = '0;
        extraDataIn = '0;
        fifoMustBeEmpty = 1'b0;
        checkBase = 0;
        errorBase = 0;
        wait (rstN === 1'b1);

        fifoMustBeEmpty <= 1'b1;
        idleCycles(RING_DEPTH);
        fifoMustBeEmpty <= 1'b0;
        finishTest(1, "reset");

        // Full cube, cube removed, odd-parity nodes removed
        driveCycle(1'b1, 16'h0000);
        idleCycles(KNOWN_GAP);
        driveCycle(1'b1, 16'hffff);
        idleCycles(KNOWN_GAP);
        driveCycle(1'b1, 16'h6996);
        idleCycles(KNOWN_GAP);
        finishTest(2, "known graphs");

        for (int i = 0; i < SPARSE_BOTS; i++) begin
            if (i % 2 == 1) begin
                driveCycle(1'b1, graphT'($random(seed) | $random(seed)));
            end else begin
                driveCycle(1'b1, graphT'($random(seed)));
            end
            idleCycles(SPARSE_GAP + $unsigned($random(seed)) % SPARSE_JITTER);
        end
        finishTest(3, "random sparse stream");

        for (int i = 0; i < BURSTS; i++) begin
            repeat (BURST_LEN) begin
                driveCycle(1'b1, graphT'($random(seed)));
            end
            idleCycles(BURST_GAP);
        end
        finishTest(4, "bursts");

        for (int g = 0; g < PATTERN_GROUPS; g++) begin
            sent = 0;
            for (int c = 0; c < PATTERN_LEN; c++) begin
                valid = (sent < BURST_LEN) && ($random(seed) & 1);
                driveCycle(valid, graphT'($random(seed)));
                sent += valid;
            end
            idleCycles(BURST_GAP);
        end
        finishTest(5, "unused slots");

        newTop = graphT'($random(seed));
        if (newTop == top) begin
            newTop = ~newTop;
        end
        @(posedge clk);
        top <= newTop;
        for (int i = 0; i < NEW_TOP_BOTS; i++) begin
            idleCycles(SPARSE_GAP + $unsigned($random(seed)) % SPARSE_JITTER);
            driveCycle(1'b1, graphT'($random(seed)));
        end
        idleCycles(1);
        finishTest(6, "new top");

        $display("%0d tests, %0d results checked, %0d errors", NUM_TESTS, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("Done: errors found");
        $finish;
    end

endmodule

/* test/connChecker.sv */
`timescale 1ns/1ps

module connChecker
    import connPkg::*;
#(
    parameter int EXTRA_W = 4
) (
    input  logic                     clk,
    input  logic                     rstN,
    input  graphT                    top,
    input  logic                     isBotValid,
    input  graphT                    bot,
    input  logic [EXTRA_W-1:0]       extraDataIn,
    input  logic [FIFO_DEPTH_LOG2:0] usedw,
    input  logic                     fifoMustBeEmpty,
    input  logic                     resultValid,
    input  countT                    connectCount,
    input  logic [EXTRA_W-1:0]       extraDataOut,
    output int                       checkCount,
    output int                       errorCount,
    output int                       pendingCount
);

    typedef struct packed {
        countT count;
        logic [EXTRA_W-1:0] extra;
        logic [31:0] dueCycle;
    } expectT;

    expectT expectQueue [$];
    logic [31:0] cycle;

    // Components of top minus bot where nodes one index bit apart are adjacent
    function automatic countT countComponents(graphT topSet, graphT botSet);
        graphT left;
        graphT comp;
        graphT next;
        logic grown;
        int count;
        int first;
        int neighbour;
        left = topSet & ~botSet;
        count = 0;
        while (left != '0) begin
            first = 0;
            while (!left[first]) begin
                first++;
            end
            comp = '0;
            comp[first] = 1'b1;
            grown = 1'b1;
            // Repeated closure until no neighbour is added
            while (grown) begin
                next = comp;
                for (int n = 0; n < GRAPH_W; n++) begin
                    for (int b = 0; b < $clog2(GRAPH_W); b++) begin
                        neighbour = n ^ (1 << b);
                        if (comp[n] && left[neighbour]) begin
                            next[neighbour] = 1'b1;
                        end
                    end
                end
                grown = (next != comp);
                comp = next;
            end
            left = left & ~comp;
            count++;
        end
        return countT'(count);
    endfunction

    initial begin
        cycle = '0;
        checkCount = 0;
        errorCount = 0;
        pendingCount = 0;
    end

    // Outputs are stable at the falling edge
    always @(negedge clk) begin : compare
        expectT head;
        expectT item;
        if (rstN === 1'b1) begin
            head = '0;
            if (expectQueue.size() != 0) begin
                head = expectQueue[0];
            end
            if (expectQueue.size() != 0 && head.dueCycle == cycle) begin
                void'(expectQueue.pop_front());
                checkCount++;
                if (resultValid !== 1'b1) begin
                    $display("FAILED resultValid at cycle %0d: expected 0x1, got 0x%h",
                             cycle, resultValid);
                    errorCount++;
                end
                if (connectCount !== head.count) begin
                    $display("FAILED connectCount at cycle %0d: expected 0x%h, got 0x%h",
                             cycle, head.count, connectCount);
                    errorCount++;
                end
                if (extraDataOut !== head.extra) begin
                    $display("FAILED extraDataOut at cycle %0d: expected 0x%h, got 0x%h",
                             cycle, head.extra, extraDataOut);
                    errorCount++;
                end
            end else if (resultValid !== 1'b0) begin
                $display("FAILED resultValid at cycle %0d: expected 0x0, got 0x%h",
                         cycle, resultValid);
                errorCount++;
            end
            if ($isunknown(usedw) || usedw > (1 << FIFO_DEPTH_LOG2) ||
                (fifoMustBeEmpty && usedw != '0)) begin
                $display("FAILED usedw at cycle %0d: limit 0x%h, got 0x%h", cycle,
                         fifoMustBeEmpty ? 0 : (1 << FIFO_DEPTH_LOG2), usedw);
                errorCount++;
            end
            if (isBotValid) begin
                item.count = countComponents(top, bot);
                item.extra = extraDataIn;
                item.dueCycle = cycle + RING_DEPTH;
                expectQueue.push_back(item);
            end
            pendingCount = expectQueue.size();
            cycle = cycle + 1;
        end
    end

endmodule

/* test/clockGen.sv */
`timescale 1ns/1ps

module clockGen (
    output logic clk,
    output logic rstN
);

    localparam int HALF_PERIOD_NS = 10;
    localparam int RESET_CYCLES = 3;

    initial begin
        clk = 1'b0;
        forever begin
            #HALF_PERIOD_NS clk = ~clk;
        end
    end

    initial begin
        rstN = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rstN <= 1'b1;
    end

endmodule

/* hw/streamingConnCore.sv */
`timescale 1ns/1ps

module streamingConnCore
    import connPkg::*;
#(
    parameter int EXTRA_W = 4
) (
    input  logic                     clk,
    input  logic                     rstN,
    input  graphT                    top,

    input  logic                     isBotValid,
    input  graphT                    bot,
    input  logic [EXTRA_W-1:0]       extraDataIn,
    output logic [FIFO_DEPTH_LOG2:0] usedw,

    output logic                     resultValid,
    output countT                    connectCount,
    output logic [EXTRA_W-1:0]       extraDataOut
);

    ringAddrT ringIndex;
    ringAddrT collectorReadAddr;
    fifoEntryT fifoIn;
    fifoEntryT engineEntry;
    logic engineRequest;
    logic engineStart;
    logic collectorWrite;
    countT engineCount;
    ringAddrT engineIndex;
    logic [EXTRA_W:0] sideOut;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            ringIndex <= '0;
        end else begin
            ringIndex <= ringIndex + 1'b1;
        end
    end

    assign fifoIn = '{bot: bot, index: ringIndex};

    graphFifo inputFifo (
        .clk(clk),
        .rstN(rstN),
        .writeEnable(isBotValid),
        .dataIn(fifoIn),
        .usedw(usedw),
        .readRequest(engineRequest),
        .dataOut(engineEntry),
        .dataOutValid(engineStart)
    );

    componentCounter engine (
        .clk(clk),
        .rstN(rstN),
        .top(top),
        .entryIn(engineEntry),
        .start(engineStart),
        .readRequest(engineRequest),
        .done(collectorWrite),
        .resultCount(engineCount),
        .resultIndex(engineIndex)
    );

    // Reading one slot ahead lines the registered output up with ringIndex
    assign collectorReadAddr = ringIndex + 1'b1;

    ringMemory #(
        .payloadT(countT),
        .DEPTH_LOG2(RING_ADDR_W)
    ) collector (
        .clk(clk),
        .writeEnable(collectorWrite),
        .writeAddr(engineIndex),
        .dataIn(engineCount),
        .readAddr(collectorReadAddr),
        .dataOut(connectCount)
    );

    sideDataStore #(
        .EXTRA_W(EXTRA_W)
    ) sideStore (
        .clk(clk),
        .rstN(rstN),
        .ringIndex(ringIndex),
        .slotIn({isBotValid, extraDataIn}),
        .slotOut(sideOut)
    );

    assign resultValid = sideOut[EXTRA_W];
    assign extraDataOut = sideOut[EXTRA_W-1:0];

    // Count must reach the collector before its slot is read back
    assert property (@(posedge clk) disable iff (!rstN)
        collectorWrite |-> ringAddrT'(ringIndex - engineIndex) < ringAddrT'(RING_DEPTH - 1))
        else $error("streamingConnCore: result for slot %0d written too late", engineIndex);

endmodule

/* hw/sideDataStore.sv */
`timescale 1ns/1ps

module sideDataStore
    import connPkg::*;
#(
    parameter int EXTRA_W = 4
) (
    input  logic             clk,
    input  logic             rstN,
    input  ringAddrT         ringIndex,

    input  logic [EXTRA_W:0] slotIn,
    output logic [EXTRA_W:0] slotOut
);

    typedef logic [(1 << CHUNK_LOG2)*(EXTRA_W+1)-1:0] chunkT;
    typedef logic [RING_ADDR_W-CHUNK_LOG2-1:0] chunkAddrT;

    chunkT packReg;
    chunkT unpackReg;
    chunkT readWord;
    chunkAddrT chunkIndex;
    chunkAddrT writeAddr;
    chunkAddrT readAddr;
    logic pushChunk;
    logic [(1 << CHUNK_LOG2)-2:0] pushPipe;
    logic firstWrapSeen;

    assign chunkIndex = ringIndex[RING_ADDR_W-1:CHUNK_LOG2];

    // Fetch the next chunk so it is ready when the unpacker drains
    assign readAddr = chunkIndex + 1'b1;

    // Oldest slot ends up in the low bits
    always_ff @(posedge clk) begin
        packReg <= {slotIn, packReg[$bits(chunkT)-1:EXTRA_W+1]};
        writeAddr <= chunkIndex;
        if (pushPipe[$bits(pushPipe)-1]) begin
            unpackReg <= readWord;
        end else begin
            unpackReg <= unpackReg >> (EXTRA_W + 1);
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pushChunk <= 1'b0;
            pushPipe <= '0;
            firstWrapSeen <= 1'b0;
        end else begin
            // Chunk complete once the low index bits wrap
            pushChunk <= &ringIndex[CHUNK_LOG2-1:0];
            pushPipe <= {pushPipe[$bits(pushPipe)-2:0], pushChunk};
            if (&ringIndex) begin
                firstWrapSeen <= 1'b1;
            end
        end
    end

    ringMemory #(
        .payloadT(chunkT),
        .DEPTH_LOG2(RING_ADDR_W - CHUNK_LOG2)
    ) chunkMemory (
        .clk(clk),
        .writeEnable(pushChunk),
        .writeAddr(writeAddr),
        .dataIn(packReg),
        .readAddr(readAddr),
        .dataOut(readWord)
    );

    // Memory holds garbage until one revolution has been written
    assign slotOut = {unpackReg[EXTRA_W] & firstWrapSeen, unpackReg[EXTRA_W-1:0]};

endmodule

/* hw/componentCounter.sv */
`timescale 1ns/1ps

module componentCounter
    import connPkg::*;
(
    input  logic      clk,
    input  logic      rstN,
    input  graphT     top,

    input  fifoEntryT entryIn,
    input  logic      start,
    output logic      readRequest,

    output logic      done,
    output countT     resultCount,
    output ringAddrT  resultIndex
);

    typedef enum logic [1:0] {
        IDLE,
        WAIT,
        BUSY
    } stateT;

    stateT state;
    logic [$clog2(FIFO_READ_LATENCY+1)-1:0] waitCount;
    graphT remaining;
    graphT component;
    graphT grown;
    graphT lowestNode;

    // Hypercube neighbours differ in exactly one index bit
    function automatic graphT neighbours(graphT nodes);
        graphT result;
        result = '0;
        for (int n = 0; n < GRAPH_W; n++) begin
            for (int d = 1; d < GRAPH_W; d = d << 1) begin
                result[n] = result[n] | nodes[n ^ d];
            end
        end
        return result;
    endfunction

    assign lowestNode = remaining & (~remaining + 1'b1);
    assign grown = component | (neighbours(component) & remaining);

    // Flood fill grows by one ring of neighbours per cycle
    always_ff @(posedge clk) begin
        if (start) begin
            remaining <= top & ~entryIn.bot;
            component <= '0;
            resultCount <= '0;
            resultIndex <= entryIn.index;
        end else if (state == BUSY) begin
            if (component == '0) begin
                component <= lowestNode;
            end else if (grown == component) begin
                // Retire the closed component
                remaining <= remaining & ~component;
                component <= '0;
                resultCount <= resultCount + 1'b1;
            end else begin
                component <= grown;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= IDLE;
            waitCount <= '0;
            readRequest <= 1'b0;
            done <= 1'b0;
        end else begin
            readRequest <= 1'b0;
            done <= 1'b0;
            case (state)
                IDLE: begin
                    readRequest <= 1'b1;
                    waitCount <= '0;
                    state <= WAIT;
                end
                WAIT: begin
                    // No data after the read latency means the FIFO was empty
                    if (start) begin
                        state <= BUSY;
                    end else if (waitCount == $bits(waitCount)'(FIFO_READ_LATENCY)) begin
                        state <= IDLE;
                    end else begin
                        waitCount <= waitCount + 1'b1;
                    end
                end
                BUSY: begin
                    if (component == '0 && remaining == '0) begin
                        done <= 1'b1;
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // FIFO data lands only when the wait window closes
    assert property (@(posedge clk) disable iff (!rstN)
        start |-> (state == WAIT && waitCount == $bits(waitCount)'(FIFO_READ_LATENCY)))
        else $error("componentCounter: start outside the request window");

    assert property (@(posedge clk) disable iff (!rstN)
        start |-> ##[1:MAX_COUNT_CYCLES] done)
        else $error("componentCounter: count took longer than MAX_COUNT_CYCLES");

endmodule

/* hw/graphFifo.sv */
`timescale 1ns/1ps

module graphFifo
    import connPkg::*;
(
    input  logic                     clk,
    input  logic                     rstN,

    input  logic                     writeEnable,
    input  fifoEntryT                dataIn,
    output logic [FIFO_DEPTH_LOG2:0] usedw,

    input  logic                     readRequest,
    output fifoEntryT                dataOut,
    output logic                     dataOutValid
);

    fifoEntryT storage [1 << FIFO_DEPTH_LOG2];
    logic [FIFO_DEPTH_LOG2-1:0] writePtr;
    logic [FIFO_DEPTH_LOG2-1:0] readPtr;
    logic isFull;
    logic isEmpty;
    logic doWrite;
    logic doRead;

    fifoEntryT pipeData [FIFO_READ_LATENCY];
    logic [FIFO_READ_LATENCY-1:0] pipeValid;

    // Count reaches the depth only when full
    assign isFull = usedw[FIFO_DEPTH_LOG2];
    assign isEmpty = (usedw == '0);

    // Requests on an empty FIFO are dropped
    assign doWrite = writeEnable && !isFull;
    assign doRead = readRequest && !isEmpty;

    always_ff @(posedge clk) begin
        if (doWrite) begin
            storage[writePtr] <= dataIn;
        end
        pipeData[0] <= storage[readPtr];
        for (int i = 1; i < FIFO_READ_LATENCY; i++) begin
            pipeData[i] <= pipeData[i-1];
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            writePtr <= '0;
            readPtr <= '0;
            usedw <= '0;
            pipeValid <= '0;
        end else begin
            if (doWrite) begin
                writePtr <= writePtr + 1'b1;
            end
            if (doRead) begin
                readPtr <= readPtr + 1'b1;
            end
            case ({doWrite, doRead})
                2'b10: usedw <= usedw + 1'b1;
                2'b01: usedw <= usedw - 1'b1;
                default: usedw <= usedw;
            endcase
            pipeValid <= {pipeValid[FIFO_READ_LATENCY-2:0], doRead};
        end
    end

    assign dataOut = pipeData[FIFO_READ_LATENCY-1];
    assign dataOutValid = pipeValid[FIFO_READ_LATENCY-1];

    // A write into a full FIFO loses the entry
    assert property (@(posedge clk) disable iff (!rstN) writeEnable |-> !isFull)
        else $error("graphFifo: write while full, entry dropped");

endmodule

/* hw/ringMemory.sv */
`timescale 1ns/1ps

module ringMemory #(
    parameter type payloadT = logic [7:0],
    parameter int DEPTH_LOG2 = 8
) (
    input  logic                  clk,

    input  logic                  writeEnable,
    input  logic [DEPTH_LOG2-1:0] writeAddr,
    input  payloadT               dataIn,

    input  logic [DEPTH_LOG2-1:0] readAddr,
    output payloadT               dataOut
);

    payloadT memory [1 << DEPTH_LOG2];

    always_ff @(posedge clk) begin
        if (writeEnable) begin
            memory[writeAddr] <= dataIn;
        end
    end

    // Registered read returns old data on a same-address write
    always_ff @(posedge clk) begin
        dataOut <= memory[readAddr];
    end

endmodule

/* hw/connPkg.sv */
package connPkg;

    // Graph size and result width
    localparam int GRAPH_W = 16;
    localparam int COUNT_W = 4;

    // One revolution of the result ring is the stream latency
    localparam int RING_ADDR_W = 8;
    localparam int RING_DEPTH = 1 << RING_ADDR_W;

    localparam int FIFO_DEPTH_LOG2 = 2;
    localparam int FIFO_READ_LATENCY = 2;

    // Side data slots per memory word
    localparam int CHUNK_LOG2 = 2;

    // Engine bound from start to done
    localparam int MAX_COUNT_CYCLES = 34;

    typedef logic [GRAPH_W-1:0] graphT;
    typedef logic [COUNT_W-1:0] countT;
    typedef logic [RING_ADDR_W-1:0] ringAddrT;

    typedef struct packed {
        graphT bot;
        ringAddrT index;
    } fifoEntryT;

endpackage
